// File: verilog/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int XLEN = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS = 32;
  localparam int MEM_WORDS = 1024;
  localparam int MEM_ADDR_W = 10;

  // base opcodes
  localparam logic [6:0] OP_LOAD = 7'b0000011;
  localparam logic [6:0] OP_STORE = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JALR = 7'b1100111;
  localparam logic [6:0] OP_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OP_JAL = 7'b1101111;
  localparam logic [6:0] OP_OP_IMM = 7'b0010011;
  localparam logic [6:0] OP_OP = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_AUIPC = 7'b0010111;
  localparam logic [6:0] OP_LUI = 7'b0110111;

  // selects sub and sra
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word, viewed in each encoding format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } rv_insn_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_t;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_IMM,
    WB_PC_PLUS4,
    WB_LOAD
  } wb_sel_t;

  typedef struct packed {
    logic       reg_we;
    alu_op_t    alu_op;
    logic       alu_src_imm;
    logic       alu_src_pc;
    wb_sel_t    wb_sel;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic       mem_read;
    logic       mem_write;
    logic [2:0] mem_funct3;
    logic       halt;
  } ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic [3:0]      be;
  } dmem_req_t;

  typedef struct packed {
    logic                  we;
    logic [MEM_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       data;
  } prog_t;

endpackage

`default_nettype wire

// File: verilog/rv_decoder.sv
`default_nettype none

module rv_decoder import rv_pkg::*; (
  input  rv_insn_t        insn,
  output ctrl_t           ctrl,
  output logic [XLEN-1:0] imm
);

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic            funct7_zero;
  logic            funct7_alt;
  logic [2:0]      funct3;

  function automatic alu_op_t alu_from_funct3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000: alu_from_funct3 = alt ? ALU_SUB : ALU_ADD;
      3'b001: alu_from_funct3 = ALU_SLL;
      3'b010: alu_from_funct3 = ALU_SLT;
      3'b011: alu_from_funct3 = ALU_SLTU;
      3'b100: alu_from_funct3 = ALU_XOR;
      3'b101: alu_from_funct3 = alt ? ALU_SRA : ALU_SRL;
      3'b110: alu_from_funct3 = ALU_OR;
      default: alu_from_funct3 = ALU_AND;
    endcase
  endfunction

  // sign-extended immediates of each format
  assign imm_i = {{(XLEN-12){insn.i.imm_11_0[11]}}, insn.i.imm_11_0};
  assign imm_s = {{(XLEN-12){insn.s.imm_11_5[6]}}, insn.s.imm_11_5, insn.s.imm_4_0};
  assign imm_b = {{(XLEN-13){insn.b.imm_12}}, insn.b.imm_12, insn.b.imm_11,
                  insn.b.imm_10_5, insn.b.imm_4_1, 1'b0};
  assign imm_u = {insn.u.imm_31_12, 12'd0};
  assign imm_j = {{(XLEN-21){insn.j.imm_20}}, insn.j.imm_20, insn.j.imm_19_12,
                  insn.j.imm_11, insn.j.imm_10_1, 1'b0};

  assign funct3 = insn.r.funct3;
  assign funct7_zero = insn.r.funct7 == 7'd0;
  assign funct7_alt = insn.r.funct7 == FUNCT7_ALT;

  always_comb begin
    // anything not matched below stays a no-op
    ctrl = '0;
    ctrl.alu_op = ALU_ADD;
    ctrl.wb_sel = WB_ALU;
    ctrl.mem_funct3 = funct3;
    imm = imm_i;
    case (insn.r.opcode)
      OP_LUI: begin
        imm = imm_u;
        ctrl.reg_we = 1'b1;
        ctrl.wb_sel = WB_IMM;
      end
      OP_AUIPC: begin
        imm = imm_u;
        ctrl.reg_we = 1'b1;
        ctrl.alu_src_pc = 1'b1;
        ctrl.alu_src_imm = 1'b1;
      end
      OP_JAL: begin
        imm = imm_j;
        ctrl.reg_we = 1'b1;
        ctrl.is_jal = 1'b1;
        ctrl.wb_sel = WB_PC_PLUS4;
      end
      OP_JALR: begin
        if (funct3 == 3'b000) begin
          ctrl.reg_we = 1'b1;
          ctrl.is_jalr = 1'b1;
          ctrl.alu_src_imm = 1'b1;
          ctrl.wb_sel = WB_PC_PLUS4;
        end
      end
      OP_BRANCH: begin
        imm = imm_b;
        // funct3 010 and 011 are unassigned
        ctrl.is_branch = funct3[2:1] != 2'b01;
      end
      OP_LOAD: begin
        if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
          ctrl.reg_we = 1'b1;
          ctrl.alu_src_imm = 1'b1;
          ctrl.mem_read = 1'b1;
          ctrl.wb_sel = WB_LOAD;
        end
      end
      OP_STORE: begin
        imm = imm_s;
        if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
          ctrl.alu_src_imm = 1'b1;
          ctrl.mem_write = 1'b1;
        end
      end
      OP_OP_IMM: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op = alu_from_funct3(funct3, funct3 == 3'b101 && funct7_alt);
        if (funct3 == 3'b001) begin
          ctrl.reg_we = funct7_zero;
        end else if (funct3 == 3'b101) begin
          ctrl.reg_we = funct7_zero | funct7_alt;
        end else begin
          ctrl.reg_we = 1'b1;
        end
      end
      OP_OP: begin
        ctrl.alu_op = alu_from_funct3(funct3, funct7_alt);
        ctrl.reg_we = funct7_zero |
                      (funct7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      OP_MISC_MEM: begin
        // fence has nothing to order here, left as a no-op
        ctrl.reg_we = 1'b0;
      end
      OP_SYSTEM: begin
        // only ecall does anything, ebreak and csr ops fall through
        ctrl.halt = insn.i.imm_11_0 == 12'd0 && insn.i.rs1 == 5'd0 &&
                    funct3 == 3'b000 && insn.i.rd == 5'd0;
      end
      default: begin
        ctrl.reg_we = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/rv_regfile.sv
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [REG_ADDR_W-1:0] rs1,
  input  logic [REG_ADDR_W-1:0] rs2,
  input  logic [REG_ADDR_W-1:0] rd,
  input  logic                  we,
  input  logic [XLEN-1:0]       wdata,
  output logic [XLEN-1:0]       rs1_data,
  output logic [XLEN-1:0]       rs2_data
);

  logic [XLEN-1:0] regs [NUM_REGS];

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < NUM_REGS; k++) begin
        regs[k] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // x0 must read zero whatever was written to it earlier
  x0_reads_zero: assert property (
    @(posedge clk) disable iff (rst)
    (rs1 == '0 |-> rs1_data == '0) and (rs2 == '0 |-> rs2_data == '0)
  );

endmodule

`default_nettype wire

// File: verilog/rv_alu.sv
`default_nettype none

module rv_alu import rv_pkg::*; (
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  input  alu_op_t         op,
  input  logic [2:0]      funct3,
  output logic [XLEN-1:0] result,
  output logic            taken
);

  logic lt_signed;
  logic lt_unsigned;
  logic equal;

  assign lt_signed = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;
  assign equal = a == b;

  always_comb begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_SLL: result = a << b[4:0];
      ALU_SLT: result = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR: result = a ^ b;
      ALU_SRL: result = a >> b[4:0];
      ALU_SRA: result = $signed(a) >>> b[4:0];
      ALU_OR: result = a | b;
      ALU_AND: result = a & b;
      default: result = '0;
    endcase
  end

  // branch condition, only looked at for branch instructions
  always_comb begin
    case (funct3)
      3'b000: taken = equal;
      3'b001: taken = !equal;
      3'b100: taken = lt_signed;
      3'b101: taken = !lt_signed;
      3'b110: taken = lt_unsigned;
      3'b111: taken = !lt_unsigned;
      default: taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/rv_lsu.sv
`default_nettype none

module rv_lsu import rv_pkg::*; (
  input  logic [XLEN-1:0] addr,
  input  logic [XLEN-1:0] store_data,
  input  logic [2:0]      funct3,
  input  logic            mem_read,
  input  logic            mem_write,
  input  logic [XLEN-1:0] rdata,
  output dmem_req_t       dreq,
  output logic [XLEN-1:0] load_value
);

  logic [1:0]      lane;
  logic [7:0]      ld_byte;
  logic [15:0]     ld_half;
  logic [XLEN-1:0] extended;

  assign lane = addr[1:0];

  // replicate the store data into every lane and let be pick the lane
  always_comb begin
    dreq.addr = {addr[XLEN-1:2], 2'b00};
    case (funct3[1:0])
      2'b00: begin
        dreq.wdata = {4{store_data[7:0]}};
        dreq.be = 4'b0001 << lane;
      end
      2'b01: begin
        dreq.wdata = {2{store_data[15:0]}};
        dreq.be = lane[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        dreq.wdata = store_data;
        dreq.be = 4'b1111;
      end
    endcase
    if (!mem_write) begin
      dreq.be = 4'b0000;
    end
  end

  // pick the load lane and zero-extend when funct3[2] is set
  assign ld_byte = rdata[8*lane +: 8];
  assign ld_half = lane[1] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    case (funct3[1:0])
      2'b00: extended = {{(XLEN-8){~funct3[2] & ld_byte[7]}}, ld_byte};
      2'b01: extended = {{(XLEN-16){~funct3[2] & ld_half[15]}}, ld_half};
      default: extended = rdata;
    endcase
    load_value = mem_read ? extended : '0;
  end

  // a half or word access off its natural alignment would hit the wrong lanes
  legal_be: assert final (
    !(mem_read || mem_write) || funct3[1:0] == 2'b00 ||
    (funct3[1:0] == 2'b01 && !lane[0]) || lane == 2'b00
  );

endmodule

`default_nettype wire

// File: verilog/rv_memory.sv
`default_nettype none

module rv_memory import rv_pkg::*; (
  input  logic            clk,
  input  prog_t           prog,
  input  logic [XLEN-1:0] pc,
  input  dmem_req_t       dreq,
  output rv_insn_t        insn,
  output logic [XLEN-1:0] rdata
);

  logic [XLEN-1:0]       mem [MEM_WORDS];
  logic [MEM_ADDR_W-1:0] pc_index;
  logic [MEM_ADDR_W-1:0] data_index;

  assign pc_index = pc[MEM_ADDR_W+1:2];
  assign data_index = dreq.addr[MEM_ADDR_W+1:2];

  // both reads see the contents from before this cycle's write
  assign insn = mem[pc_index];
  assign rdata = mem[data_index];

  always_ff @(posedge clk) begin
    for (int lane = 0; lane < 4; lane++) begin
      if (dreq.be[lane]) begin
        mem[data_index][8*lane +: 8] <= dreq.wdata[8*lane +: 8];
      end
    end
    // program loading wins over a store to the same word
    if (prog.we) begin
      mem[prog.addr] <= prog.data;
    end
  end

  pc_aligned: assert property (
    @(posedge clk) !$isunknown(pc) |-> pc[1:0] == 2'b00
  );

  store_aligned: assert property (
    @(posedge clk) dreq.be != 4'b0000 |-> dreq.addr[1:0] == 2'b00
  );

endmodule

`default_nettype wire

// File: verilog/rv_core.sv
`default_nettype none

module rv_core import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  rv_insn_t        insn,
  input  logic [XLEN-1:0] rdata,
  output logic [XLEN-1:0] pc,
  output dmem_req_t       dreq,
  output logic            halt
);

  ctrl_t           ctrl;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] alu_a;
  logic [XLEN-1:0] alu_b;
  logic [XLEN-1:0] alu_result;
  logic            taken;
  logic [XLEN-1:0] load_value;
  logic [XLEN-1:0] wb_data;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] pc_next;
  logic            active;
  dmem_req_t       lsu_req;

  rv_decoder decoder0 (
    .insn (insn),
    .ctrl (ctrl),
    .imm  (imm)
  );

  rv_regfile regfile0 (
    .clk      (clk),
    .rst      (rst),
    .rs1      (insn.r.rs1),
    .rs2      (insn.r.rs2),
    .rd       (insn.r.rd),
    .we       (ctrl.reg_we & ~halt),
    .wdata    (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign alu_a = ctrl.alu_src_pc ? pc : rs1_data;
  assign alu_b = ctrl.alu_src_imm ? imm : rs2_data;

  rv_alu alu0 (
    .a      (alu_a),
    .b      (alu_b),
    .op     (ctrl.alu_op),
    .funct3 (insn.b.funct3),
    .result (alu_result),
    .taken  (taken)
  );

  rv_lsu lsu0 (
    .addr       (alu_result),
    .store_data (rs2_data),
    .funct3     (ctrl.mem_funct3),
    .mem_read   (ctrl.mem_read),
    .mem_write  (ctrl.mem_write),
    .rdata      (rdata),
    .dreq       (lsu_req),
    .load_value (load_value)
  );

  assign pc_plus4 = pc + XLEN'(4);

  always_comb begin
    if (ctrl.is_jalr) begin
      pc_next = {alu_result[XLEN-1:1], 1'b0};
    end else if (ctrl.is_jal || (ctrl.is_branch && taken)) begin
      pc_next = pc + imm;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_comb begin
    case (ctrl.wb_sel)
      WB_IMM: wb_data = imm;
      WB_PC_PLUS4: wb_data = pc_plus4;
      WB_LOAD: wb_data = load_value;
      default: wb_data = alu_result;
    endcase
  end

  // no stores leave the core while memory is being loaded or after ecall
  assign active = ~rst & ~halt;

  always_comb begin
    dreq = lsu_req;
    dreq.be = active ? lsu_req.be : 4'b0000;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
      halt <= 1'b0;
    end else if (!halt) begin
      pc <= pc_next;
      halt <= ctrl.halt;
    end
  end

endmodule

`default_nettype wire

// File: verilog/rv_system.sv
`default_nettype none

module rv_system import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  prog_t     prog,
  output logic      halt,
  output dmem_req_t store
);

  logic [XLEN-1:0] pc;
  dmem_req_t       dreq;
  rv_insn_t        insn;
  logic [XLEN-1:0] rdata;

  rv_core core0 (
    .clk   (clk),
    .rst   (rst),
    .insn  (insn),
    .rdata (rdata),
    .pc    (pc),
    .dreq  (dreq),
    .halt  (halt)
  );

  rv_memory memory0 (
    .clk   (clk),
    .prog  (prog),
    .pc    (pc),
    .dreq  (dreq),
    .insn  (insn),
    .rdata (rdata)
  );

  // the data request doubles as the observable store port
  assign store = dreq;

endmodule

`default_nettype wire

// File: bench/rv_iss.svh
`ifndef RV_ISS_SVH
`define RV_ISS_SVH

logic [31:0] prog_img [$];
dmem_req_t   exp_q [$];
logic [31:0] lcg_state;
int          slot;

// result slots start at byte 0x400, above every program image
localparam int SLOT_BASE = 'h400;
localparam logic [31:0] ECALL = 32'h00000073;

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                       input int f3, input int rd, input logic [6:0] opc);
  return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc};
endfunction

function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                       input int rd, input logic [6:0] opc);
  return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
endfunction

function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1,
                                       input int f3);
  return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OP_STORE};
endfunction

function automatic logic [31:0] b_type(input int off, input int rs1, input int rs2,
                                       input int f3);
  return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OP_BRANCH};
endfunction

function automatic logic [31:0] u_type(input int imm20, input int rd, input logic [6:0] opc);
  return {imm20[19:0], rd[4:0], opc};
endfunction

function automatic logic [31:0] j_type(input int off, input int rd);
  return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OP_JAL};
endfunction

function automatic void start_program();
  prog_img.delete();
  slot = 0;
endfunction

function automatic void emit(input logic [31:0] w);
  prog_img.push_back(w);
endfunction

// sw rN into the next result slot, x0 as base
function automatic void save_reg(input int r);
  emit(s_type(SLOT_BASE + 4 * slot, r, 0, 2));
  slot++;
endfunction

// lui part is rounded so the signed addi lands on v
function automatic void load_const(input int r, input logic [31:0] v);
  emit(u_type(v[31:12] + v[11], r, OP_LUI));
  emit(i_type(v[11:0], r, 0, r, OP_OP_IMM));
endfunction

function automatic logic [31:0] byte_mask(input logic [3:0] be);
  logic [31:0] mask;
  for (int k = 0; k < 4; k++) begin
    mask[8*k +: 8] = {8{be[k]}};
  end
  return mask;
endfunction

function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: return (a < b) ? 32'd1 : 32'd0;
    3'd4: return a ^ b;
    3'd5: begin
      if (alt) begin
        return $signed(a) >>> b[4:0];
      end
      return a >> b[4:0];
    end
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
  case (f3)
    3'd0: return a == b;
    3'd1: return a != b;
    3'd4: return $signed(a) < $signed(b);
    3'd5: return $signed(a) >= $signed(b);
    3'd6: return a < b;
    3'd7: return a >= b;
    default: return 1'b0;
  endcase
endfunction

// runs prog_img from pc 0 until ecall and fills exp_q with the stores
function automatic void rv_iss(input int max_steps);
  logic [31:0] x [32];
  logic [31:0] m [MEM_WORDS];
  logic [31:0] pc;
  logic [31:0] w;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic [31:0] res;
  logic [31:0] ea;
  logic [31:0] nxt;
  logic [31:0] ld;
  logic [31:0] wd;
  logic [6:0]  f7;
  logic [2:0]  f3;
  logic [4:0]  rd;
  logic [3:0]  be;
  logic        we;
  dmem_req_t   req;
  for (int k = 0; k < 32; k++) begin
    x[k] = '0;
  end
  for (int k = 0; k < MEM_WORDS; k++) begin
    m[k] = (k < prog_img.size()) ? prog_img[k] : '0;
  end
  exp_q.delete();
  pc = '0;
  for (int step = 0; step < max_steps; step++) begin
    w = m[pc[MEM_ADDR_W+1:2]];
    if (w == ECALL) begin
      break;
    end
    f7 = w[31:25];
    f3 = w[14:12];
    rd = w[11:7];
    a = x[w[19:15]];
    b = x[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_u = {w[31:12], 12'd0};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    nxt = pc + 32'd4;
    we = 1'b0;
    res = '0;
    case (w[6:0])
      OP_LUI: begin
        res = imm_u;
        we = 1'b1;
      end
      OP_AUIPC: begin
        res = pc + imm_u;
        we = 1'b1;
      end
      OP_JAL: begin
        res = pc + 32'd4;
        we = 1'b1;
        nxt = pc + imm_j;
      end
      OP_JALR: begin
        if (f3 == 3'd0) begin
          res = pc + 32'd4;
          we = 1'b1;
          nxt = (a + imm_i) & ~32'd1;
        end
      end
      OP_BRANCH: begin
        if (branch_taken(f3, a, b)) begin
          nxt = pc + imm_b;
        end
      end
      OP_LOAD: begin
        ea = a + imm_i;
        ld = m[ea[MEM_ADDR_W+1:2]] >> (8 * ea[1:0]);
        we = 1'b1;
        case (f3)
          3'd0: res = {{24{ld[7]}}, ld[7:0]};
          3'd1: res = {{16{ld[15]}}, ld[15:0]};
          3'd2: res = ld;
          3'd4: res = {24'd0, ld[7:0]};
          3'd5: res = {16'd0, ld[15:0]};
          default: we = 1'b0;
        endcase
      end
      OP_STORE: begin
        ea = a + imm_s;
        wd = b << (8 * ea[1:0]);
        case (f3)
          3'd0: be = 4'b0001 << ea[1:0];
          3'd1: be = 4'b0011 << ea[1:0];
          3'd2: be = 4'b1111;
          default: be = 4'b0000;
        endcase
        for (int k = 0; k < 4; k++) begin
          if (be[k]) begin
            m[ea[MEM_ADDR_W+1:2]][8*k +: 8] = wd[8*k +: 8];
          end
        end
        if (be != 4'b0000) begin
          req.addr = {ea[31:2], 2'b00};
          req.wdata = wd & byte_mask(be);
          req.be = be;
          exp_q.push_back(req);
        end
      end
      OP_OP_IMM: begin
        we = !(f3 == 3'd1 && f7 != 7'd0) &&
             !(f3 == 3'd5 && f7 != 7'd0 && f7 != FUNCT7_ALT);
        res = alu_model(f3, f3 == 3'd5 && f7 == FUNCT7_ALT, a, imm_i);
      end
      OP_OP: begin
        we = f7 == 7'd0 || (f7 == FUNCT7_ALT && (f3 == 3'd0 || f3 == 3'd5));
        res = alu_model(f3, f7 == FUNCT7_ALT, a, b);
      end
      default: begin
        // fence, other system words and unknown encodings change nothing
        we = 1'b0;
      end
    endcase
    if (we && rd != 5'd0) begin
      x[rd] = res;
    end
    pc = nxt;
  end
endfunction

`endif

// File: bench/tb_rv_system.sv
`default_nettype none

module tb_rv_system import rv_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALT_TIMEOUT = 4000;
  localparam int ISS_STEPS = 4000;

  logic      clk;
  logic      rst;
  prog_t     prog;
  logic      halt;
  dmem_req_t store;

  int        test_errors;
  int        all_errors;
  int        tests_passed;
  int        tests_failed;
  int        got_count;
  logic      prev_rst;
  dmem_req_t want;

  `include "rv_iss.svh"

  rv_system dut0 (
    .clk   (clk),
    .rst   (rst),
    .prog  (prog),
    .halt  (halt),
    .store (store)
  );

  always #2 clk = ~clk;

  task automatic value_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    test_errors++;
  endtask

  task automatic note_problem(input string msg);
    $display("at %0t ns the run went wrong: %s", $time, msg);
    test_errors++;
  endtask

  // the store monitor samples at the rising edge that closes each cycle
  always @(posedge clk) begin
    if (rst) begin
      if (store.be !== 4'b0000) begin
        value_mismatch($sformatf("store enables %b while reset is high", store.be));
      end
      if (prev_rst && halt !== 1'b0) begin
        value_mismatch($sformatf("halt is %b while reset is high", halt));
      end
    end else if (store.be !== 4'b0000) begin
      if (halt === 1'b1) begin
        value_mismatch($sformatf("store with enables %b after halt", store.be));
      end else if (got_count >= exp_q.size()) begin
        note_problem($sformatf("an extra store to address %h that the model never made",
                               store.addr));
      end else begin
        want = exp_q[got_count];
        if (store.addr !== want.addr || store.be !== want.be ||
            (store.wdata & byte_mask(store.be)) !== want.wdata) begin
          value_mismatch($sformatf("store %0d got %h/%b/%h, expected %h/%b/%h",
                                   got_count, store.addr, store.be,
                                   store.wdata & byte_mask(store.be),
                                   want.addr, want.be, want.wdata));
        end
      end
      got_count++;
    end
    prev_rst = rst;
  end

  // reload the whole memory under reset, run to halt, then report
  task automatic run_test(input string name);
    int cycles;
    test_errors = 0;
    got_count = 0;
    rv_iss(ISS_STEPS);
    @(posedge clk);
    rst <= 1'b1;
    for (int k = 0; k < MEM_WORDS; k++) begin
      @(posedge clk);
      prog.we <= 1'b1;
      prog.addr <= k[MEM_ADDR_W-1:0];
      prog.data <= (k < prog_img.size()) ? prog_img[k] : '0;
    end
    @(posedge clk);
    prog <= '0;
    @(posedge clk);
    rst <= 1'b0;
    cycles = 0;
    while (halt !== 1'b1 && cycles < HALT_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (halt !== 1'b1) begin
      note_problem($sformatf("halt did not rise within %0d cycles", HALT_TIMEOUT));
    end
    // quiet period after halt
    repeat (10) @(posedge clk);
    if (got_count < exp_q.size()) begin
      note_problem($sformatf("only %0d of %0d expected stores were seen",
                             got_count, exp_q.size()));
    end
    all_errors += test_errors;
    if (test_errors == 0) begin
      $display("test %-8s passed, %0d stores matched", name, got_count);
      tests_passed++;
    end else begin
      $display("test %-8s failed with %0d errors", name, test_errors);
      tests_failed++;
    end
  endtask

  function automatic void reset_program();
    start_program();
    save_reg(0);
    emit(i_type(42, 0, 0, 1, OP_OP_IMM));
    save_reg(1);
    emit(ECALL);
  endfunction

  function automatic void alu_program();
    start_program();
    load_const(1, 32'h8000_0005);
    emit(i_type(-3, 0, 0, 2, OP_OP_IMM));
    emit(i_type(7, 0, 0, 3, OP_OP_IMM));
    for (int f3 = 0; f3 < 8; f3++) begin
      emit(r_type(0, 2, 1, f3, 5, OP_OP));
      save_reg(5);
      emit(r_type(0, 3, 2, f3, 6, OP_OP));
      save_reg(6);
    end
    // sub and sra
    emit(r_type(FUNCT7_ALT, 2, 1, 0, 5, OP_OP));
    save_reg(5);
    emit(r_type(FUNCT7_ALT, 3, 1, 5, 5, OP_OP));
    save_reg(5);
    emit(r_type(FUNCT7_ALT, 3, 2, 5, 6, OP_OP));
    save_reg(6);
    for (int n = 0; n < 8; n++) begin
      if (n != 1 && n != 5) begin
        emit(i_type(-5, 1, n, 5, OP_OP_IMM));
        save_reg(5);
        emit(i_type(12, 2, n, 6, OP_OP_IMM));
        save_reg(6);
      end
    end
    emit(i_type(3, 1, 1, 5, OP_OP_IMM));
    save_reg(5);
    emit(i_type(4, 1, 5, 5, OP_OP_IMM));
    save_reg(5);
    // srai carries funct7 0x20 in imm[11:5]
    emit(i_type('h404, 1, 5, 5, OP_OP_IMM));
    save_reg(5);
    emit(ECALL);
  endfunction

  function automatic void branch_program();
    int loop_at;
    int call_at;
    int skip_at;
    int func_at;
    int end_at;
    start_program();
    emit(i_type(5, 0, 0, 9, OP_OP_IMM));
    emit(u_type('h80000, 2, OP_LUI));
    emit(i_type(1, 0, 0, 3, OP_OP_IMM));
    loop_at = prog_img.size();
    emit(i_type(3, 4, 0, 4, OP_OP_IMM));
    save_reg(4);
    emit(i_type(-1, 9, 0, 9, OP_OP_IMM));
    emit(b_type(4 * (loop_at - prog_img.size()), 9, 0, 1));
    // x2 is negative signed but large unsigned
    emit(b_type(8, 2, 3, 4));
    emit(i_type(99, 0, 0, 6, OP_OP_IMM));
    save_reg(6);
    emit(b_type(8, 2, 3, 7));
    emit(i_type(55, 0, 0, 7, OP_OP_IMM));
    emit(b_type(8, 2, 3, 6));
    emit(i_type(11, 7, 0, 7, OP_OP_IMM));
    save_reg(7);
    emit(b_type(8, 2, 3, 5));
    emit(i_type(1, 0, 0, 8, OP_OP_IMM));
    emit(b_type(8, 3, 3, 0));
    emit(i_type(77, 0, 0, 8, OP_OP_IMM));
    save_reg(8);
    call_at = prog_img.size();
    emit('0);
    save_reg(10);
    save_reg(1);
    skip_at = prog_img.size();
    emit('0);
    func_at = prog_img.size();
    emit(i_type(123, 0, 0, 10, OP_OP_IMM));
    // the odd offset makes the target drop bit 0
    emit(i_type(1, 1, 0, 11, OP_JALR));
    end_at = prog_img.size();
    save_reg(11);
    emit(ECALL);
    prog_img[call_at] = j_type(4 * (func_at - call_at), 1);
    prog_img[skip_at] = j_type(4 * (end_at - skip_at), 0);
  endfunction

  function automatic void width_program();
    start_program();
    load_const(1, 32'h1234_5678);
    load_const(2, 32'hFFFF_FF81);
    for (int k = 0; k < 4; k++) begin
      emit(s_type('h600 + k, k[0] ? 2 : 1, 0, 0));
    end
    emit(s_type('h604, 2, 0, 1));
    emit(s_type('h606, 1, 0, 1));
    for (int k = 0; k < 4; k++) begin
      emit(i_type('h600 + k, 0, 0, 5, OP_LOAD));
      save_reg(5);
      emit(i_type('h600 + k, 0, 4, 5, OP_LOAD));
      save_reg(5);
    end
    for (int k = 0; k < 8; k += 2) begin
      emit(i_type('h600 + k, 0, 1, 5, OP_LOAD));
      save_reg(5);
      emit(i_type('h600 + k, 0, 5, 5, OP_LOAD));
      save_reg(5);
    end
    emit(i_type('h600, 0, 2, 5, OP_LOAD));
    save_reg(5);
    emit(i_type('h604, 0, 2, 5, OP_LOAD));
    save_reg(5);
    emit(ECALL);
  endfunction

  function automatic void upper_program();
    start_program();
    emit(u_type('hABCDE, 1, OP_LUI));
    emit(u_type('h12345, 2, OP_AUIPC));
    emit(u_type('hFFFFF, 3, OP_AUIPC));
    emit(u_type(0, 4, OP_AUIPC));
    for (int r = 5; r < 32; r++) begin
      emit(i_type(r * 37 - 600, 0, 0, r, OP_OP_IMM));
    end
    for (int r = 1; r < 5; r++) begin
      save_reg(r);
    end
    // fence iorw with the ignored rd and rs1 fields set, so a stray write to x5 shows
    emit(i_type('h0FF, 6, 0, 5, OP_MISC_MEM));
    for (int r = 1; r < 32; r++) begin
      save_reg(r);
    end
    emit(ECALL);
  endfunction

  function automatic void random_program();
    logic [31:0] r;
    int          f3;
    int          imm;
    start_program();
    for (int k = 1; k < 32; k++) begin
      load_const(k, lcg_next());
    end
    for (int n = 0; n < 64; n++) begin
      r = lcg_next();
      f3 = r[17:15];
      if (r[18]) begin
        emit(r_type((r[19] && (f3 == 0 || f3 == 5)) ? FUNCT7_ALT : 0,
                    r[14:10], r[9:5], f3, r[4:0], OP_OP));
      end else begin
        if (f3 == 1) begin
          imm = r[24:20];
        end else if (f3 == 5) begin
          imm = (r[19] ? 'h400 : 0) | r[24:20];
        end else begin
          imm = r[31:20];
        end
        emit(i_type(imm, r[9:5], f3, r[4:0], OP_OP_IMM));
      end
    end
    for (int k = 1; k < 32; k++) begin
      save_reg(k);
    end
    emit(ECALL);
  endfunction

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    prog = '0;
    all_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    got_count = 0;
    lcg_state = 32'd77253;
    reset_program();
    run_test("reset");
    alu_program();
    run_test("alu");
    branch_program();
    run_test("control");
    width_program();
    run_test("widths");
    upper_program();
    run_test("upper");
    random_program();
    run_test("random");
    $display("tests passed %0d, failed %0d, errors %0d",
             tests_passed, tests_failed, all_errors);
    if (tests_failed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+bench
verilog/rv_pkg.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_lsu.sv
verilog/rv_memory.sv
verilog/rv_core.sv
verilog/rv_system.sv
bench/tb_rv_system.sv
